// ==== dv/turf_ps_regs_stimulus.txt ====
# op addr data expect, hex. P: addr = pulses, data = spacing in cycles, expect = pulses seen
# I: data in EMIO_IN layout. O: expect = resetb[11:8] oe[7:4] extint[1:0]. D: data = 2nd addr
O 0000 00000000 00000000
R 0000 00000000 54555246
R 0001 00000000 9a2b1234
W 0002 a5c30f96 00000000
R 0002 00000000 a5c30f96
R 1400 00000000 badacce5
R 0007 00000000 badacce5
W 0000 12345678 00000000
R 0000 00000000 54555246
W 0400 00001000 00000000
P 0003 00000020 00000003
R 0400 00000000 00001003
D 0402 00000403 00000020
W 0800 0000a300 00000000
W 0801 00003200 00000000
O 0000 00000000 00000ac1
R 0801 00000000 00003200
I 0000 00005801 00000000
R 0802 00000000 00005c01
R 0802 00000000 00005801
P 0001 00000010 00000001
R 0802 00000000 00005c01
R 0802 00000000 00005801

// ==== sources.f ====
src/turf_reg_pkg.sv
src/turf_board_pkg.sv
src/turf_wb_if.sv
src/turf_intercon.sv
src/turf_id_ctrl.sv
src/turf_pps_time.sv
src/turf_emio_gpio.sv
src/turf_ps_regs.sv
dv/turf_ps_regs_tb.sv

// ==== Bender.yml ====
package:
  name: turf_ps_regs

sources:
  - files:
      - src/turf_reg_pkg.sv
      - src/turf_board_pkg.sv
      - src/turf_wb_if.sv
      - src/turf_intercon.sv
      - src/turf_id_ctrl.sv
      - src/turf_pps_time.sv
      - src/turf_emio_gpio.sv
      - src/turf_ps_regs.sv
  - target: test
    files:
      - dv/turf_ps_regs_tb.sv

// ==== dv/turf_ps_regs_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_ps_regs_tb;

    localparam int CLK_HALF_NS = 20;
    localparam int RESET_CYC   = 16;
    localparam int CYC_PER_OP  = 400;
    localparam int ACK_LIMIT   = 8;
    localparam int PPS_HIGH    = 4;

    logic        ps_clk;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [13:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        gps_pps_i;
    logic        gps_timepulse1_i;
    logic        uart_irq_b_i;
    logic [3:0]  tio_resetb_i;
    logic        pps_pulse_o;
    logic [3:0]  tio_resetb_o;
    logic [3:0]  tio_resetb_oe_o;
    logic [1:0]  gps_extint_o;

    // Parsed stimulus with one entry per operation line
    logic [7:0]  op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    logic        stim_loaded = 1'b0;

    int mismatches   = 0;
    int other_errors = 0;
    int pulses_seen  = 0;

    turf_ps_regs #(
        .VER_MAJOR     (4'd1),
        .VER_MINOR     (4'd2),
        .VER_REV       (8'h34),
        .FIRMWARE_DATE (16'h1A2B),
        .REV_B         (1'b1)
    ) i_turf_ps_regs (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .gps_pps_i        (gps_pps_i),
        .gps_timepulse1_i (gps_timepulse1_i),
        .uart_irq_b_i     (uart_irq_b_i),
        .tio_resetb_i     (tio_resetb_i),
        .pps_pulse_o      (pps_pulse_o),
        .tio_resetb_o     (tio_resetb_o),
        .tio_resetb_oe_o  (tio_resetb_oe_o),
        .gps_extint_o     (gps_extint_o)
    );

    initial ps_clk = 1'b0;
    always #CLK_HALF_NS ps_clk = ~ps_clk;

    // Counts cycles with the PPS pulse high
    always @(posedge ps_clk) begin
        if (pps_pulse_o === 1'b1) begin
            pulses_seen <= pulses_seen + 1;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s: got %h, expected %h", $time, what, actual,
                     expected);
            mismatches++;
        end
    endtask

    // Input drive point shortly after the rising edge
    task automatic next_edge();
        @(posedge ps_clk);
        #2;
    endtask

    // Output sample point ahead of any new drive
    task automatic sample_point();
        @(posedge ps_clk);
        #1;
    endtask

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("dv/turf_ps_regs_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file dv/turf_ps_regs_stimulus.txt");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%c %h %h %h", op, a, d, e);
                    if (n == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        exp_q.push_back(e);
                    end else begin
                        $display("malformed stimulus line: %s", line);
                        other_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One classic cycle with ack on the second strobe cycle
    task automatic wb_access(input logic we, input logic [13:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int gap;
        int cycles;
        gap = $urandom % 4;
        repeat (gap) @(posedge ps_clk);
        next_edge();
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        // Ack must stay low in the first strobe cycle
        #1;
        check_value(wb_ack_o, 32'd0, "ack in the first strobe cycle");
        cycles   = 0;
        do begin
            sample_point();
            cycles++;
        end while (wb_ack_o !== 1'b1 && cycles < ACK_LIMIT);
        if (wb_ack_o !== 1'b1) begin
            $display("no Wishbone ack for address %h within %0d cycles", adr, ACK_LIMIT);
            other_errors++;
        end
        check_value(cycles, 32'd1, "ack latency in cycles");
        rdata = wb_dat_o;
        next_edge();
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic pps_pulses(input int count, input int spacing,
                              input logic [31:0] expected);
        int seen_before;
        seen_before = pulses_seen;
        if (spacing < 2 * PPS_HIGH) begin
            $display("PPS spacing of %0d cycles is too short", spacing);
            other_errors++;
        end else begin
            for (int i = 0; i < count; i++) begin
                next_edge();
                gps_pps_i = 1'b1;
                repeat (PPS_HIGH - 1) next_edge();
                gps_pps_i = 1'b0;
                repeat (spacing - PPS_HIGH) next_edge();
            end
        end
        check_value(pulses_seen - seen_before, expected, "pps_pulse_o pulse count");
    endtask

    //////////////////////////////////////////////////
    // Watchdog
    //////////////////////////////////////////////////
    initial begin
        longint limit;
        wait (stim_loaded);
        limit = longint'(op_q.size()) * CYC_PER_OP + RESET_CYC;
        repeat (limit) @(posedge ps_clk);
        $display("run timed out after %0d clock cycles", limit);
        $display("test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd_a;
        logic [31:0] rd_b;
        logic [31:0] outs;
        void'($urandom(14228));
        rst_n_i          = 1'b0;
        wb_cyc_i         = 1'b0;
        wb_stb_i         = 1'b0;
        wb_we_i          = 1'b0;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        gps_pps_i        = 1'b0;
        gps_timepulse1_i = 1'b0;
        uart_irq_b_i     = 1'b0;
        tio_resetb_i     = '0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYC) @(posedge ps_clk);
        #2;
        rst_n_i = 1'b1;

        sample_point();
        check_value(wb_ack_o, 32'd0, "wb_ack_o after reset");
        check_value(pps_pulse_o, 32'd0, "pps_pulse_o after reset");

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "W": wb_access(1'b1, addr_q[i][13:0], data_q[i], rd_a);
                "R": begin
                    wb_access(1'b0, addr_q[i][13:0], '0, rd_a);
                    check_value(rd_a, exp_q[i], $sformatf("read of %h", addr_q[i][13:0]));
                end
                // Difference of two reads with the second address in the data field
                "D": begin
                    wb_access(1'b0, addr_q[i][13:0], '0, rd_a);
                    wb_access(1'b0, data_q[i][13:0], '0, rd_b);
                    check_value(rd_a - rd_b, exp_q[i],
                                $sformatf("%h minus %h", addr_q[i][13:0], data_q[i][13:0]));
                end
                "P": pps_pulses(addr_q[i], data_q[i], exp_q[i]);
                "I": begin
                    next_edge();
                    tio_resetb_i     = data_q[i][15:12];
                    gps_timepulse1_i = data_q[i][11];
                    uart_irq_b_i     = data_q[i][0];
                end
                "O": begin
                    sample_point();
                    outs = {20'd0, tio_resetb_o, tio_resetb_oe_o, 2'b00, gps_extint_o};
                    check_value(outs, exp_q[i], "reset, enable and EXTINT outputs");
                end
                default: begin
                    $display("unknown stimulus opcode %c on operation %0d", op_q[i], i);
                    other_errors++;
                end
            endcase
        end

        repeat (4) @(posedge ps_clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/turf_ps_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_ps_regs #(
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd6,
    parameter logic [7:0]  VER_REV       = 8'd0,
    parameter logic [15:0] FIRMWARE_DATE = 16'd0,
    parameter logic        REV_B         = 1'b0
) (
    input  logic                                  ps_clk,
    input  logic                                  rst_n_i,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [turf_reg_pkg::WB_ADDR_W-1:0]    wb_adr_i,
    input  logic [turf_reg_pkg::WB_DATA_W-1:0]    wb_dat_i,
    output logic [turf_reg_pkg::WB_DATA_W-1:0]    wb_dat_o,
    output logic                                  wb_ack_o,
    input  logic                                  gps_pps_i,
    input  logic                                  gps_timepulse1_i,
    input  logic                                  uart_irq_b_i,
    input  logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_i,
    output logic                                  pps_pulse_o,
    output logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_o,
    output logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_oe_o,
    output logic [1:0]                            gps_extint_o
);

    turf_wb_if wb_up ();
    turf_wb_if wb_id ();
    turf_wb_if wb_time ();
    turf_wb_if wb_emio ();

    // Plain Wishbone ports onto the upstream bus
    assign wb_up.cyc      = wb_cyc_i;
    assign wb_up.stb      = wb_stb_i;
    assign wb_up.we       = wb_we_i;
    assign wb_up.adr.word = wb_adr_i;
    assign wb_up.dat_m    = wb_dat_i;
    assign wb_dat_o       = wb_up.dat_s;
    assign wb_ack_o       = wb_up.ack;

    //////////////////////////////////////////////////
    // Interconnect and register blocks
    //////////////////////////////////////////////////
    turf_intercon u_intercon (
        .ps_clk   (ps_clk),
        .rst_n_i  (rst_n_i),
        .m_bus_i  (wb_up.slave),
        .s_id_o   (wb_id.master),
        .s_time_o (wb_time.master),
        .s_emio_o (wb_emio.master)
    );

    turf_id_ctrl #(
        .VER_MAJOR     (VER_MAJOR),
        .VER_MINOR     (VER_MINOR),
        .VER_REV       (VER_REV),
        .FIRMWARE_DATE (FIRMWARE_DATE),
        .REV_B         (REV_B)
    ) u_id_ctrl (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .bus_i   (wb_id.slave)
    );

    turf_pps_time u_pps_time (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .pps_i       (gps_pps_i),
        .bus_i       (wb_time.slave),
        .pps_pulse_o (pps_pulse_o)
    );

    // PPS flag in EMIO follows the time block's pulse
    turf_emio_gpio u_emio_gpio (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .pps_pulse_i      (pps_pulse_o),
        .gps_timepulse1_i (gps_timepulse1_i),
        .uart_irq_b_i     (uart_irq_b_i),
        .tio_resetb_i     (tio_resetb_i),
        .bus_i            (wb_emio.slave),
        .tio_resetb_o     (tio_resetb_o),
        .tio_resetb_oe_o  (tio_resetb_oe_o),
        .gps_extint_o     (gps_extint_o)
    );

endmodule

`default_nettype wire

// ==== src/turf_emio_gpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_emio_gpio (
    input  logic                                 ps_clk,
    input  logic                                 rst_n_i,
    input  logic                                 pps_pulse_i,
    input  logic                                 gps_timepulse1_i,
    input  logic                                 uart_irq_b_i,
    input  logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_i,
    turf_wb_if.slave                             bus_i,
    output logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_o,
    output logic [turf_board_pkg::NUM_TURFIO-1:0] tio_resetb_oe_o,
    output logic [1:0]                           gps_extint_o
);
    import turf_reg_pkg::*;
    import turf_board_pkg::*;

    logic                 strobe;
    logic                 ack_q;
    logic                 wr_en;
    logic                 in_read_done;
    logic [EMIO_W-1:0]    out_q;
    logic [EMIO_W-1:0]    tri_q;
    logic [EMIO_W-1:0]    emio_in;
    logic                 pps_flag_q;
    logic [WB_DATA_W-1:0] rdata;

    assign strobe       = bus_i.cyc & bus_i.stb;
    assign wr_en        = strobe & ack_q & bus_i.we;
    assign in_read_done = strobe & ack_q & ~bus_i.we & (bus_i.adr.field.index == IDX_EMIO_IN);

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            out_q      <= '0;
            tri_q      <= '1;
            pps_flag_q <= 1'b0;
        end else begin
            ack_q <= strobe & ~ack_q;
            if (wr_en && bus_i.adr.field.index == IDX_EMIO_OUT) begin
                out_q <= bus_i.dat_m[EMIO_W-1:0];
            end
            if (wr_en && bus_i.adr.field.index == IDX_EMIO_TRI) begin
                tri_q <= bus_i.dat_m[EMIO_W-1:0];
            end
            // A new pulse beats the clearing read
            if (pps_pulse_i) begin
                pps_flag_q <= 1'b1;
            end else if (in_read_done) begin
                pps_flag_q <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Pin decode and readback
    //////////////////////////////////////////////////
    assign tio_resetb_o    = out_q[EMIO_TIO_RESET_LSB +: NUM_TURFIO];
    assign tio_resetb_oe_o = ~tri_q[EMIO_TIO_RESET_LSB +: NUM_TURFIO];
    assign gps_extint_o    = {out_q[EMIO_EXTINT1] & ~tri_q[EMIO_EXTINT1],
                              out_q[EMIO_EXTINT0] & ~tri_q[EMIO_EXTINT0]};

    always_comb begin
        emio_in                                  = '0;
        emio_in[EMIO_TIO_RESET_LSB +: NUM_TURFIO] = tio_resetb_i;
        emio_in[EMIO_TIMEPULSE1]                  = gps_timepulse1_i;
        emio_in[EMIO_PPS]                         = pps_flag_q;
        emio_in[EMIO_UART_IRQ]                    = uart_irq_b_i;
    end

    always_comb begin
        rdata = UNMAPPED_WORD;
        case (bus_i.adr.field.index)
            IDX_EMIO_OUT: rdata = {{(WB_DATA_W - EMIO_W){1'b0}}, out_q};
            IDX_EMIO_TRI: rdata = {{(WB_DATA_W - EMIO_W){1'b0}}, tri_q};
            IDX_EMIO_IN:  rdata = {{(WB_DATA_W - EMIO_W){1'b0}}, emio_in};
            default:      rdata = UNMAPPED_WORD;
        endcase
    end

    assign bus_i.dat_s = rdata;
    assign bus_i.ack   = ack_q;

endmodule

`default_nettype wire

// ==== src/turf_pps_time.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_pps_time (
    input  logic     ps_clk,
    input  logic     rst_n_i,
    input  logic     pps_i,
    turf_wb_if.slave bus_i,
    output logic     pps_pulse_o
);
    import turf_reg_pkg::*;

    logic                 strobe;
    logic                 ack_q;
    logic                 sec_wr;
    // Bits 1:0 synchronizer, bits 3:2 edge detect
    logic [3:0]           pps_sr_q;
    logic                 pps_rise;
    logic                 pulse_q;
    logic [WB_DATA_W-1:0] cur_sec_q;
    logic [WB_DATA_W-1:0] cur_time_q;
    logic [WB_DATA_W-1:0] last_pps_q;
    logic [WB_DATA_W-1:0] llast_pps_q;
    logic [WB_DATA_W-1:0] rdata;

    assign strobe   = bus_i.cyc & bus_i.stb;
    assign sec_wr   = strobe & ack_q & bus_i.we & (bus_i.adr.field.index == IDX_CUR_SEC);
    assign pps_rise = pps_sr_q[2] & ~pps_sr_q[3];

    //////////////////////////////////////////////////
    // PPS capture and time counters
    //////////////////////////////////////////////////
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            pps_sr_q    <= '0;
            pulse_q     <= 1'b0;
            cur_sec_q   <= '0;
            cur_time_q  <= '0;
            last_pps_q  <= '0;
            llast_pps_q <= '0;
        end else begin
            ack_q      <= strobe & ~ack_q;
            pps_sr_q   <= {pps_sr_q[2:0], pps_i};
            pulse_q    <= pps_rise;
            cur_time_q <= cur_time_q + 1'b1;
            // Software load of the seconds wins over a PPS tick
            if (sec_wr) begin
                cur_sec_q <= bus_i.dat_m;
            end else if (pps_rise) begin
                cur_sec_q <= cur_sec_q + 1'b1;
            end
            if (pps_rise) begin
                last_pps_q  <= cur_time_q;
                llast_pps_q <= last_pps_q;
            end
        end
    end

    always_comb begin
        case (bus_i.adr.field.index)
            IDX_CUR_SEC:   rdata = cur_sec_q;
            IDX_CUR_TIME:  rdata = cur_time_q;
            IDX_LAST_PPS:  rdata = last_pps_q;
            IDX_LLAST_PPS: rdata = llast_pps_q;
            default:       rdata = UNMAPPED_WORD;
        endcase
    end

    assign bus_i.dat_s = rdata;
    assign bus_i.ack   = ack_q;
    assign pps_pulse_o = pulse_q;

    a_pulse_single: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        pps_pulse_o |=> !pps_pulse_o)
        else $error("PPS pulse wider than one cycle");

endmodule

`default_nettype wire

// ==== src/turf_id_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_id_ctrl #(
    parameter logic [3:0]  VER_MAJOR     = 4'd0,
    parameter logic [3:0]  VER_MINOR     = 4'd6,
    parameter logic [7:0]  VER_REV       = 8'd0,
    parameter logic [15:0] FIRMWARE_DATE = 16'd0,
    parameter logic        REV_B         = 1'b0
) (
    input  logic     ps_clk,
    input  logic     rst_n_i,
    turf_wb_if.slave bus_i
);
    import turf_reg_pkg::*;
    import turf_board_pkg::*;

    localparam logic [31:0] DATEVERSION =
        pack_datever(REV_B, FIRMWARE_DATE, VER_MAJOR, VER_MINOR, VER_REV);

    logic                 strobe;
    logic                 ack_q;
    logic                 wr_en;
    logic [WB_DATA_W-1:0] scratch_q;
    logic [WB_DATA_W-1:0] rdata;

    assign strobe = bus_i.cyc & bus_i.stb;
    // Writes land at the end of the ack cycle
    assign wr_en  = strobe & ack_q & bus_i.we;

    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q     <= 1'b0;
            scratch_q <= '0;
        end else begin
            ack_q <= strobe & ~ack_q;
            if (wr_en && bus_i.adr.field.index == IDX_SCRATCH) begin
                scratch_q <= bus_i.dat_m;
            end
        end
    end

    always_comb begin
        case (bus_i.adr.field.index)
            IDX_IDENT:   rdata = TURF_IDENT;
            IDX_DATEVER: rdata = DATEVERSION;
            IDX_SCRATCH: rdata = scratch_q;
            default:     rdata = UNMAPPED_WORD;
        endcase
    end

    assign bus_i.dat_s = rdata;
    assign bus_i.ack   = ack_q;

    a_single_ack: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        ack_q |=> !ack_q)
        else $error("ID block ack held for two cycles");

endmodule

`default_nettype wire

// ==== src/turf_intercon.sv ====
`timescale 1ns/1ps
`default_nettype none

module turf_intercon (
    input  logic      ps_clk,
    input  logic      rst_n_i,
    turf_wb_if.slave  m_bus_i,
    turf_wb_if.master s_id_o,
    turf_wb_if.master s_time_o,
    turf_wb_if.master s_emio_o
);
    import turf_reg_pkg::*;

    logic strobe;
    logic sel_id;
    logic sel_time;
    logic sel_emio;
    logic sel_none;
    logic none_ack_q;

    // Space decode, the only place the space field is looked at
    assign strobe   = m_bus_i.cyc & m_bus_i.stb;
    assign sel_id   = (m_bus_i.adr.field.space == SPACE_ID);
    assign sel_time = (m_bus_i.adr.field.space == SPACE_TIME);
    assign sel_emio = (m_bus_i.adr.field.space == SPACE_EMIO);
    assign sel_none = ~(sel_id | sel_time | sel_emio);

    //////////////////////////////////////////////////
    // Request fan-out
    //////////////////////////////////////////////////
    assign s_id_o.cyc     = m_bus_i.cyc & sel_id;
    assign s_id_o.stb     = m_bus_i.stb & sel_id;
    assign s_id_o.we      = m_bus_i.we;
    assign s_id_o.adr     = m_bus_i.adr;
    assign s_id_o.dat_m   = m_bus_i.dat_m;

    assign s_time_o.cyc   = m_bus_i.cyc & sel_time;
    assign s_time_o.stb   = m_bus_i.stb & sel_time;
    assign s_time_o.we    = m_bus_i.we;
    assign s_time_o.adr   = m_bus_i.adr;
    assign s_time_o.dat_m = m_bus_i.dat_m;

    assign s_emio_o.cyc   = m_bus_i.cyc & sel_emio;
    assign s_emio_o.stb   = m_bus_i.stb & sel_emio;
    assign s_emio_o.we    = m_bus_i.we;
    assign s_emio_o.adr   = m_bus_i.adr;
    assign s_emio_o.dat_m = m_bus_i.dat_m;

    // Unmapped spaces get the same one-cycle ack as a real slave
    always_ff @(posedge ps_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= strobe & sel_none & ~none_ack_q;
        end
    end

    // Response mux
    always_comb begin
        m_bus_i.ack   = none_ack_q;
        m_bus_i.dat_s = UNMAPPED_WORD;
        if (sel_id) begin
            m_bus_i.ack   = s_id_o.ack;
            m_bus_i.dat_s = s_id_o.dat_s;
        end else if (sel_time) begin
            m_bus_i.ack   = s_time_o.ack;
            m_bus_i.dat_s = s_time_o.dat_s;
        end else if (sel_emio) begin
            m_bus_i.ack   = s_emio_o.ack;
            m_bus_i.dat_s = s_emio_o.dat_s;
        end
    end

    a_one_slave: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $onehot0({s_id_o.stb, s_time_o.stb, s_emio_o.stb}))
        else $error("more than one slave strobed");

    a_ack_in_cycle: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        m_bus_i.ack |-> m_bus_i.cyc)
        else $error("ack seen outside of a bus cycle");

endmodule

`default_nettype wire

// ==== src/turf_wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface turf_wb_if;
    import turf_reg_pkg::*;

    logic                 cyc;
    logic                 stb;
    logic                 we;
    reg_addr_u            adr;
    logic [WB_DATA_W-1:0] dat_m;
    logic [WB_DATA_W-1:0] dat_s;
    logic                 ack;

    modport master (
        output cyc, stb, we, adr, dat_m,
        input  dat_s, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_m,
        output dat_s, ack
    );

endinterface

`default_nettype wire

// ==== src/turf_board_pkg.sv ====
`default_nettype none

package turf_board_pkg;

    localparam int EMIO_W     = 16;
    localparam int NUM_TURFIO = 4;

    // ASCII "TURF"
    localparam logic [31:0] TURF_IDENT = 32'h54555246;

    //////////////////////////////////////////////////
    // EMIO bank bit map
    //////////////////////////////////////////////////
    localparam int EMIO_UART_IRQ      = 0;
    localparam int EMIO_EXTINT0       = 8;
    localparam int EMIO_EXTINT1       = 9;
    localparam int EMIO_PPS           = 10;
    localparam int EMIO_TIMEPULSE1    = 11;
    localparam int EMIO_TIO_RESET_LSB = 12;

    // Date/version word fields
    localparam int DV_REVB_BIT  = 31;
    localparam int DV_DATE_LSB  = 16;
    localparam int DV_MAJOR_LSB = 12;
    localparam int DV_MINOR_LSB = 8;
    localparam int DV_REV_LSB   = 0;

    function automatic logic [31:0] pack_datever(input logic        rev_b,
                                                 input logic [15:0] fw_date,
                                                 input logic [3:0]  major,
                                                 input logic [3:0]  minor,
                                                 input logic [7:0]  rev);
        logic [31:0] word;
        word = '0;
        word[DV_REVB_BIT]          = rev_b;
        // Only 15 bits of the date fit
        word[DV_DATE_LSB +: 15]    = fw_date[14:0];
        word[DV_MAJOR_LSB +: 4]    = major;
        word[DV_MINOR_LSB +: 4]    = minor;
        word[DV_REV_LSB +: 8]      = rev;
        return word;
    endfunction

endpackage

`default_nettype wire

// ==== src/turf_reg_pkg.sv ====
`default_nettype none

package turf_reg_pkg;

    // Wishbone geometry
    localparam int WB_DATA_W   = 32;
    localparam int WB_ADDR_W   = 14;
    localparam int REG_SPACE_W = 4;
    localparam int REG_INDEX_W = WB_ADDR_W - REG_SPACE_W;

    // Address spaces seen by the interconnect
    typedef enum logic [REG_SPACE_W-1:0] {
        SPACE_ID   = 4'd0,
        SPACE_TIME = 4'd1,
        SPACE_EMIO = 4'd2
    } reg_space_e;

    typedef struct packed {
        logic [REG_SPACE_W-1:0] space;
        logic [REG_INDEX_W-1:0] index;
    } reg_field_t;

    // Word address, flat or split into space and register index
    typedef union packed {
        logic [WB_ADDR_W-1:0] word;
        reg_field_t           field;
    } reg_addr_u;

    //////////////////////////////////////////////////
    // Register indices inside each space
    //////////////////////////////////////////////////
    localparam logic [REG_INDEX_W-1:0] IDX_IDENT     = 10'd0;
    localparam logic [REG_INDEX_W-1:0] IDX_DATEVER   = 10'd1;
    localparam logic [REG_INDEX_W-1:0] IDX_SCRATCH   = 10'd2;

    localparam logic [REG_INDEX_W-1:0] IDX_CUR_SEC   = 10'd0;
    localparam logic [REG_INDEX_W-1:0] IDX_CUR_TIME  = 10'd1;
    localparam logic [REG_INDEX_W-1:0] IDX_LAST_PPS  = 10'd2;
    localparam logic [REG_INDEX_W-1:0] IDX_LLAST_PPS = 10'd3;

    localparam logic [REG_INDEX_W-1:0] IDX_EMIO_OUT  = 10'd0;
    localparam logic [REG_INDEX_W-1:0] IDX_EMIO_TRI  = 10'd1;
    localparam logic [REG_INDEX_W-1:0] IDX_EMIO_IN   = 10'd2;

    // Read value for holes in the map
    localparam logic [WB_DATA_W-1:0] UNMAPPED_WORD = 32'hBADACCE5;

endpackage

`default_nettype wire
